// File: design/dsp_pkg.sv
package dsp_pkg;

	// readout channels sharing the result memory
	localparam int NCHAN = 4;

	// sample and weight component width
	localparam int SAMPLE_W = 16;

	// accumulator width inside mix_acc, result width after shift
	localparam int ACCINT_W = 40;
	localparam int ACC_W = 32;
	localparam int SHIFT_W = 5;

	// samples per integration window
	localparam int INTEG_LEN = 16;

	// result memory geometry, address is {channel, slot}
	localparam int SLOT_W = 4;
	localparam int CHAN_W = 2;
	localparam int MEM_ADDR_W = CHAN_W + SLOT_W;
	localparam int MEM_DATA_W = 2 * ACC_W;

	localparam int SHOT_W = 32;

	// baseband source select, code 3 also gives zero
	typedef enum logic [1:0] {
		SEL_ADC0 = 2'd0,
		SEL_ADC1 = 2'd1,
		SEL_ZERO = 2'd2
	} bb_sel_t;

endpackage

// File: design/acc_wr_if.sv
`timescale 1ns/1ps

// one channel's result on its way to the arbiter
interface acc_wr_if;
	import dsp_pkg::*;

	logic valid;
	logic ready;
	logic [ACC_W-1:0] accx;
	logic [ACC_W-1:0] accy;

	// accumulator side
	modport src (
		output valid,
		output accx,
		output accy,
		input ready
	);

	// arbiter side
	modport dst (
		input valid,
		input accx,
		input accy,
		output ready
	);

endinterface

// File: design/bb_select.sv
`timescale 1ns/1ps

module bb_select (
	input logic dspif,
	input logic reset,
	input logic [dsp_pkg::SAMPLE_W-1:0] adc0,
	input logic [dsp_pkg::SAMPLE_W-1:0] adc1,
	input dsp_pkg::bb_sel_t mixbbxsel,
	input dsp_pkg::bb_sel_t mixbbysel,
	output logic [dsp_pkg::SAMPLE_W-1:0] bbx,
	output logic [dsp_pkg::SAMPLE_W-1:0] bby
);
	import dsp_pkg::*;

	logic [SAMPLE_W-1:0] adc0_r;
	logic [SAMPLE_W-1:0] adc1_r;

	always_ff @(posedge dspif) begin
		if (reset) begin
			adc0_r <= '0;
			adc1_r <= '0;
			bbx <= '0;
			bby <= '0;
		end else begin
			adc0_r <= adc0;
			adc1_r <= adc1;
			// unlisted codes fall through to zero
			case (mixbbxsel)
				SEL_ADC0: bbx <= adc0_r;
				SEL_ADC1: bbx <= adc1_r;
				default: bbx <= '0;
			endcase
			case (mixbbysel)
				SEL_ADC0: bby <= adc0_r;
				SEL_ADC1: bby <= adc1_r;
				default: bby <= '0;
			endcase
		end
	end

endmodule

// File: design/shot_sequencer.sv
`timescale 1ns/1ps

module shot_sequencer (
	input logic dspif,
	input logic reset,
	input logic stb_start,
	input logic [dsp_pkg::SHOT_W-1:0] nshot,
	input logic [dsp_pkg::NCHAN-1:0] chan_busy,
	output logic shot_start,
	output logic [dsp_pkg::SHOT_W-1:0] shotcnt,
	output logic busy,
	output logic lastshotdone
);
	import dsp_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		START,
		WAIT,
		NEXT,
		DONE
	} state_t;

	state_t state;
	state_t nextstate;
	logic [SHOT_W-1:0] nshot_l;
	logic wait_armed;
	logic last_shot;

	assign last_shot = (shotcnt == nshot_l - 1'b1);

	always_comb begin
		nextstate = state;
		case (state)
			IDLE: if (stb_start) nextstate = START;
			START: nextstate = WAIT;
			// first WAIT cycle always stays, channels raise busy meanwhile
			WAIT: if (wait_armed && ~|chan_busy) nextstate = NEXT;
			NEXT: nextstate = last_shot ? DONE : START;
			DONE: nextstate = IDLE;
			default: nextstate = IDLE;
		endcase
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			state <= IDLE;
			shotcnt <= '0;
			nshot_l <= SHOT_W'(1);
			wait_armed <= 1'b0;
		end else begin
			state <= nextstate;
			wait_armed <= (state == WAIT);
			if (state == IDLE) begin
				// a zero count runs a single shot
				nshot_l <= (nshot == '0) ? SHOT_W'(1) : nshot;
				if (stb_start)
					shotcnt <= '0;
			end
			if (state == NEXT && !last_shot)
				shotcnt <= shotcnt + 1'b1;
		end
	end

	assign shot_start = (state == START);
	assign busy = (state != IDLE) && (state != DONE);
	assign lastshotdone = (state == DONE);

endmodule

// File: design/mix_acc.sv
`timescale 1ns/1ps

module mix_acc (
	input logic dspif,
	input logic reset,
	input logic shot_start,
	input logic [dsp_pkg::SAMPLE_W-1:0] bbx,
	input logic [dsp_pkg::SAMPLE_W-1:0] bby,
	input logic [dsp_pkg::SAMPLE_W-1:0] coefx,
	input logic [dsp_pkg::SAMPLE_W-1:0] coefy,
	input logic [dsp_pkg::SHIFT_W-1:0] shift,
	output logic busy,
	acc_wr_if.src wr
);
	import dsp_pkg::*;

	logic signed [2*SAMPLE_W:0] prod_re;
	logic signed [2*SAMPLE_W:0] prod_im;
	logic signed [ACCINT_W-1:0] acc_x;
	logic signed [ACCINT_W-1:0] acc_y;
	logic signed [ACCINT_W-1:0] scaled_x;
	logic signed [ACCINT_W-1:0] scaled_y;
	logic [$clog2(INTEG_LEN)-1:0] cnt;
	logic acc_on;

	// complex multiply of baseband sample by channel weight
	assign prod_re = $signed(bbx) * $signed(coefx) - $signed(bby) * $signed(coefy);
	assign prod_im = $signed(bbx) * $signed(coefy) + $signed(bby) * $signed(coefx);

	always_ff @(posedge dspif) begin
		if (shot_start) begin
			acc_x <= '0;
			acc_y <= '0;
		end else if (acc_on) begin
			acc_x <= acc_x + prod_re;
			acc_y <= acc_y + prod_im;
		end
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			acc_on <= 1'b0;
			cnt <= '0;
			busy <= 1'b0;
			wr.valid <= 1'b0;
		end else if (shot_start) begin
			acc_on <= 1'b1;
			cnt <= '0;
			busy <= 1'b1;
		end else begin
			if (acc_on) begin
				cnt <= cnt + 1'b1;
				// last sample of the window
				if (cnt == INTEG_LEN - 1) begin
					acc_on <= 1'b0;
					wr.valid <= 1'b1;
				end
			end
			if (wr.valid && wr.ready) begin
				wr.valid <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	// sums stay put while valid waits for the arbiter
	assign scaled_x = acc_x >>> shift;
	assign scaled_y = acc_y >>> shift;
	assign wr.accx = scaled_x[ACC_W-1:0];
	assign wr.accy = scaled_y[ACC_W-1:0];

endmodule

// File: design/accbuf_arbiter.sv
`timescale 1ns/1ps

module accbuf_arbiter (
	input logic dspif,
	input logic reset,
	input logic resetacc,
	acc_wr_if.dst wr [dsp_pkg::NCHAN],
	output logic we,
	output logic [dsp_pkg::MEM_ADDR_W-1:0] waddr,
	output logic [dsp_pkg::MEM_DATA_W-1:0] wdata
);
	import dsp_pkg::*;

	logic [NCHAN-1:0] valid;
	logic [ACC_W-1:0] accx_a [NCHAN];
	logic [ACC_W-1:0] accy_a [NCHAN];
	logic [SLOT_W-1:0] slot [NCHAN];
	logic [CHAN_W-1:0] rr_ptr;
	logic [CHAN_W-1:0] gnt_idx;
	logic gnt_any;

	for (genvar i = 0; i < NCHAN; i++) begin : g_chan
		assign valid[i] = wr[i].valid;
		assign accx_a[i] = wr[i].accx;
		assign accy_a[i] = wr[i].accy;
		assign wr[i].ready = gnt_any && (gnt_idx == CHAN_W'(i));
	end

	// scan from the far end so the channel nearest rr_ptr wins
	always_comb begin
		logic [CHAN_W-1:0] cand;
		gnt_any = 1'b0;
		gnt_idx = rr_ptr;
		for (int k = NCHAN - 1; k >= 0; k--) begin
			cand = rr_ptr + CHAN_W'(k);
			if (valid[cand]) begin
				gnt_any = 1'b1;
				gnt_idx = cand;
			end
		end
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			rr_ptr <= '0;
			we <= 1'b0;
		end else begin
			we <= gnt_any;
			if (gnt_any)
				rr_ptr <= gnt_idx + 1'b1;
		end
	end

	// slot counters stick at the last slot
	always_ff @(posedge dspif) begin
		if (reset || resetacc) begin
			for (int i = 0; i < NCHAN; i++)
				slot[i] <= '0;
		end else if (gnt_any && !(&slot[gnt_idx])) begin
			slot[gnt_idx] <= slot[gnt_idx] + 1'b1;
		end
	end

	always_ff @(posedge dspif) begin
		waddr <= {gnt_idx, slot[gnt_idx]};
		wdata <= {accx_a[gnt_idx], accy_a[gnt_idx]};
	end

endmodule

// File: design/acc_mem.sv
`timescale 1ns/1ps

module acc_mem (
	input logic dspif,
	input logic we,
	input logic [dsp_pkg::MEM_ADDR_W-1:0] waddr,
	input logic [dsp_pkg::MEM_DATA_W-1:0] wdata,
	input logic [dsp_pkg::MEM_ADDR_W-1:0] rd_addr,
	output logic [dsp_pkg::MEM_DATA_W-1:0] rd_data
);
	import dsp_pkg::*;

	logic [MEM_DATA_W-1:0] mem [2**MEM_ADDR_W];

	always_ff @(posedge dspif) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// one cycle read latency
	always_ff @(posedge dspif) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: design/dsp_readout.sv
`timescale 1ns/1ps

module dsp_readout (
	input logic dspif,
	input logic reset,
	input logic stb_start,
	input logic [dsp_pkg::SHOT_W-1:0] nshot,
	input logic resetacc,
	input logic [dsp_pkg::SAMPLE_W-1:0] adc0,
	input logic [dsp_pkg::SAMPLE_W-1:0] adc1,
	input dsp_pkg::bb_sel_t mixbbxsel,
	input dsp_pkg::bb_sel_t mixbbysel,
	input logic [dsp_pkg::SHIFT_W-1:0] shift,
	input logic [dsp_pkg::NCHAN-1:0][dsp_pkg::SAMPLE_W-1:0] coefx,
	input logic [dsp_pkg::NCHAN-1:0][dsp_pkg::SAMPLE_W-1:0] coefy,
	input logic [dsp_pkg::MEM_ADDR_W-1:0] rd_addr,
	output logic [dsp_pkg::MEM_DATA_W-1:0] rd_data,
	output logic [dsp_pkg::SHOT_W-1:0] shotcnt,
	output logic busy,
	output logic lastshotdone
);
	import dsp_pkg::*;

	logic [SAMPLE_W-1:0] bbx;
	logic [SAMPLE_W-1:0] bby;
	logic shot_start;
	logic [NCHAN-1:0] chan_busy;
	logic we;
	logic [MEM_ADDR_W-1:0] waddr;
	logic [MEM_DATA_W-1:0] wdata;

	acc_wr_if wr_if [NCHAN] ();

	bb_select bb_select_inst (
		.dspif(dspif),
		.reset(reset),
		.adc0(adc0),
		.adc1(adc1),
		.mixbbxsel(mixbbxsel),
		.mixbbysel(mixbbysel),
		.bbx(bbx),
		.bby(bby)
	);

	shot_sequencer shot_sequencer_inst (
		.dspif(dspif),
		.reset(reset),
		.stb_start(stb_start),
		.nshot(nshot),
		.chan_busy(chan_busy),
		.shot_start(shot_start),
		.shotcnt(shotcnt),
		.busy(busy),
		.lastshotdone(lastshotdone)
	);

	// one mixer per readout channel, each with its own weight
	for (genvar i = 0; i < NCHAN; i++) begin : g_mix
		mix_acc mix_acc_inst (
			.dspif(dspif),
			.reset(reset),
			.shot_start(shot_start),
			.bbx(bbx),
			.bby(bby),
			.coefx(coefx[i]),
			.coefy(coefy[i]),
			.shift(shift),
			.busy(chan_busy[i]),
			.wr(wr_if[i])
		);
	end

	accbuf_arbiter accbuf_arbiter_inst (
		.dspif(dspif),
		.reset(reset),
		.resetacc(resetacc),
		.wr(wr_if),
		.we(we),
		.waddr(waddr),
		.wdata(wdata)
	);

	acc_mem acc_mem_inst (
		.dspif(dspif),
		.we(we),
		.waddr(waddr),
		.wdata(wdata),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

// File: tb/tb_dsp_readout.sv
`timescale 1ns/1ps

module tb_dsp_readout;
	import dsp_pkg::*;

	localparam int DRIVE_DLY = 1;
	localparam int NWORDS = 2**MEM_ADDR_W;
	localparam int NMULTI = 5;

	logic dspif;
	logic reset;
	logic stb_start;
	logic [SHOT_W-1:0] nshot;
	logic resetacc;
	logic [SAMPLE_W-1:0] adc0;
	logic [SAMPLE_W-1:0] adc1;
	bb_sel_t mixbbxsel;
	bb_sel_t mixbbysel;
	logic [SHIFT_W-1:0] shift;
	logic [NCHAN-1:0][SAMPLE_W-1:0] coefx;
	logic [NCHAN-1:0][SAMPLE_W-1:0] coefy;
	logic [MEM_ADDR_W-1:0] rd_addr;
	logic [MEM_DATA_W-1:0] rd_data;
	logic [SHOT_W-1:0] shotcnt;
	logic busy;
	logic lastshotdone;

	integer seed = 32'h9308_e72a;
	int cycles = 0;
	int cycle_limit = 200;
	int total_shots = 0;
	int done_pulses = 0;
	int runs_done = 0;

	// reference model state
	logic [MEM_DATA_W-1:0] exp_mem [NWORDS];
	logic exp_set [NWORDS];
	logic [SLOT_W-1:0] slot_m [NCHAN];

	dsp_readout dsp_readout_inst (
		.dspif(dspif),
		.reset(reset),
		.stb_start(stb_start),
		.nshot(nshot),
		.resetacc(resetacc),
		.adc0(adc0),
		.adc1(adc1),
		.mixbbxsel(mixbbxsel),
		.mixbbysel(mixbbysel),
		.shift(shift),
		.coefx(coefx),
		.coefy(coefy),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.shotcnt(shotcnt),
		.busy(busy),
		.lastshotdone(lastshotdone)
	);

	initial begin
		dspif = 1'b0;
		forever #50 dspif = ~dspif;
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped after a failure");
	endtask

	// limit grows as each run is started
	always @(posedge dspif) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
			stop_with_failure("timeout: the run took more cycles than its limit");
	end

	// every high cycle of the done flag over the whole test
	always @(posedge dspif) begin
		if (lastshotdone)
			done_pulses <= done_pulses + 1;
	end

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED: %s got %h expected %h",
				name, got, exp));
	endtask

	task automatic step();
		@(posedge dspif);
		#DRIVE_DLY;
	endtask

	function automatic logic [SAMPLE_W-1:0] bb_value(input logic [1:0] code,
			input logic [SAMPLE_W-1:0] a0, input logic [SAMPLE_W-1:0] a1);
		if (code == 2'd0)
			return a0;
		if (code == 2'd1)
			return a1;
		return '0;
	endfunction

	// complex product summed over the window then shifted and truncated
	function automatic logic [MEM_DATA_W-1:0] chan_result(input logic [SAMPLE_W-1:0] bx,
			input logic [SAMPLE_W-1:0] by, input logic [SAMPLE_W-1:0] cx,
			input logic [SAMPLE_W-1:0] cy, input logic [SHIFT_W-1:0] sh);
		longint re;
		longint im;
		re = longint'($signed(bx)) * longint'($signed(cx))
			- longint'($signed(by)) * longint'($signed(cy));
		im = longint'($signed(bx)) * longint'($signed(cy))
			+ longint'($signed(by)) * longint'($signed(cx));
		re = (re * INTEG_LEN) >>> sh;
		im = (im * INTEG_LEN) >>> sh;
		return {re[ACC_W-1:0], im[ACC_W-1:0]};
	endfunction

	task automatic read_word(input int addr, output logic [MEM_DATA_W-1:0] data);
		rd_addr = MEM_ADDR_W'(addr);
		step();
		data = rd_data;
	endtask

	task automatic check_memory();
		logic [MEM_DATA_W-1:0] data;
		for (int a = 0; a < NWORDS; a++) begin
			if (exp_set[a]) begin
				read_word(a, data);
				check_value($sformatf("rd_data[%0d]", a), data, exp_mem[a]);
			end
		end
	endtask

	task automatic run_shots(input logic [SHOT_W-1:0] n, input bb_sel_t sx, input bb_sel_t sy);
		logic [31:0] rnd;
		logic [SHOT_W-1:0] eff;
		logic [SHOT_W-1:0] prev;
		logic [MEM_DATA_W-1:0] res;
		logic [SAMPLE_W-1:0] bx;
		logic [SAMPLE_W-1:0] by;
		int addr;
		eff = (n == '0) ? SHOT_W'(1) : n;
		cycle_limit = cycle_limit + 40 * int'(eff) + 200;
		total_shots = total_shots + int'(eff);
		rnd = $random(seed);
		adc0 = rnd[15:0];
		adc1 = rnd[31:16];
		rnd = $random(seed);
		shift = rnd[SHIFT_W-1:0];
		for (int c = 0; c < NCHAN; c++) begin
			rnd = $random(seed);
			coefx[c] = rnd[15:0];
			coefy[c] = rnd[31:16];
		end
		mixbbxsel = sx;
		mixbbysel = sy;
		nshot = n;
		repeat (3) step();
		// every shot of a run sees the same held inputs
		bx = bb_value(sx, adc0, adc1);
		by = bb_value(sy, adc0, adc1);
		for (int c = 0; c < NCHAN; c++) begin
			res = chan_result(bx, by, coefx[c], coefy[c], shift);
			for (int s = 0; s < int'(eff); s++) begin
				addr = c * (2**SLOT_W) + int'(slot_m[c]);
				exp_mem[addr] = res;
				exp_set[addr] = 1'b1;
				if (slot_m[c] != '1)
					slot_m[c] = slot_m[c] + 1'b1;
			end
		end
		stb_start = 1'b1;
		step();
		stb_start = 1'b0;
		// first shot starts one cycle after the strobe
		check_value("shotcnt", 64'(shotcnt), 64'h0);
		prev = '0;
		while (!lastshotdone) begin
			check_value("busy", 64'(busy), 64'h1);
			if (shotcnt == prev + 1'b1 && prev + 1'b1 < eff)
				prev = prev + 1'b1;
			check_value("shotcnt", 64'(shotcnt), 64'(prev));
			step();
		end
		check_value("busy", 64'(busy), 64'h0);
		check_value("shotcnt", 64'(shotcnt), 64'(eff - 1'b1));
		step();
		check_value("lastshotdone", 64'(lastshotdone), 64'h0);
		check_memory();
		runs_done = runs_done + 1;
		check_value("lastshotdone pulses", 64'(done_pulses), 64'(runs_done));
	endtask

	initial begin
		logic [31:0] rnd;
		reset = 1'b1;
		stb_start = 1'b0;
		nshot = '0;
		resetacc = 1'b0;
		adc0 = '0;
		adc1 = '0;
		mixbbxsel = SEL_ADC0;
		mixbbysel = SEL_ADC0;
		shift = '0;
		coefx = '0;
		coefy = '0;
		rd_addr = '0;
		for (int a = 0; a < NWORDS; a++)
			exp_set[a] = 1'b0;
		for (int c = 0; c < NCHAN; c++)
			slot_m[c] = '0;

		repeat (16) step();
		reset = 1'b0;
		step();
		check_value("busy", 64'(busy), 64'h0);
		check_value("lastshotdone", 64'(lastshotdone), 64'h0);
		check_value("shotcnt", 64'(shotcnt), 64'h0);

		// single shots with a zero count among them
		for (int r = 0; r < 4; r++) begin
			rnd = $random(seed);
			run_shots(SHOT_W'(r % 2), bb_sel_t'(rnd[1:0]), bb_sel_t'(rnd[3:2]));
		end

		for (int r = 0; r < NMULTI; r++) begin
			rnd = $random(seed);
			run_shots(SHOT_W'(rnd[7:0] % 6 + 1), bb_sel_t'(rnd[9:8]), bb_sel_t'(rnd[11:10]));
		end

		// push every channel well past its last slot
		while (total_shots <= 2**SLOT_W + 4) begin
			rnd = $random(seed);
			run_shots(SHOT_W'(6), bb_sel_t'(rnd[1:0]), bb_sel_t'(rnd[3:2]));
		end

		resetacc = 1'b1;
		step();
		resetacc = 1'b0;
		for (int c = 0; c < NCHAN; c++)
			slot_m[c] = '0;
		run_shots(SHOT_W'(3), SEL_ADC0, SEL_ADC1);

		// zero source on both paths including code 3
		run_shots(SHOT_W'(1), SEL_ZERO, SEL_ZERO);
		run_shots(SHOT_W'(1), bb_sel_t'(2'd3), bb_sel_t'(2'd3));

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: files.f
design/dsp_pkg.sv
design/acc_wr_if.sv
design/bb_select.sv
design/shot_sequencer.sv
design/mix_acc.sv
design/accbuf_arbiter.sv
design/acc_mem.sv
design/dsp_readout.sv
tb/tb_dsp_readout.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_dsp_readout -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_dsp_readout > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1
